/* files.f */
design/g729_pkg.sv
design/lane_if.sv
design/scratch_mem.sv
design/int_lpc_ctrl.sv
design/interp_lane.sv
design/result_collector.sv
design/int_lpc_top.sv
dv/int_lpc_tb.sv

/* Bender.yml */
package:
  name: int_lpc

sources:
  - design/g729_pkg.sv
  - design/lane_if.sv
  - design/scratch_mem.sv
  - design/int_lpc_ctrl.sv
  - design/interp_lane.sv
  - design/result_collector.sv
  - design/int_lpc_top.sv
  - target: test
    files:
      - dv/int_lpc_tb.sv

/* dv/int_lpc_tb.sv */
module int_lpc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_lanes = 2;
	localparam int done_cycle = 2 * g729_pkg::lpc_order + 4;
	localparam int done_limit = done_cycle + 16;

	// Watchdog budget
	localparam int test_slots = 20;
	localparam int slot_cycles = 40;
	localparam int clock_period = 10;

	localparam g729_pkg::word16 known_new [10] = '{
		-32768, 32767, -1, 1, 0, 12345, -12345, 32767, -32768, 2
	};
	localparam g729_pkg::word16 known_old [10] = '{
		-32768, 32767, -1, -1, 32767, -2, 3, -32768, 32767, 0
	};

	logic clock;
	logic reset;
	logic start;
	logic busy;
	logic done;
	logic host_write_en;
	g729_pkg::mem_addr host_addr;
	g729_pkg::word16 host_write_data;
	g729_pkg::mem_addr host_read_addr;
	g729_pkg::word16 host_read_data;

	g729_pkg::word16 model [64];
	logic [15:0] lfsr_state;
	string test_name;
	int tests;
	int checks;
	int errors;

	int_lpc_top #(.num_lanes(num_lanes)) i_int_lpc_top (
		.clock(clock),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.host_write_en(host_write_en),
		.host_addr(host_addr),
		.host_write_data(host_write_data),
		.host_read_addr(host_read_addr),
		.host_read_data(host_read_data)
	);

	always #5 clock = ~clock;

	initial begin
		#(test_slots * slot_cycles * clock_period);
		$display("Watchdog expired, the DUT stopped responding");
		$display("Test FAILED");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois LFSR with x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic g729_pkg::word16 random_word();
		g729_pkg::word16 w;
		w = '0;
		for (int k = 0; k < 16; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[14:0], lfsr_state[0]};
		end
		return w;
	endfunction

	function automatic g729_pkg::word16 interpolate(input g729_pkg::word16 n,
			input g729_pkg::word16 o);
		return (n >>> 1) + (o >>> 1);
	endfunction

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic check_word(input string what, input g729_pkg::word16 expected,
			input g729_pkg::word16 actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic host_write(input g729_pkg::mem_addr addr, input g729_pkg::word16 data);
		host_write_en = 1'b1;
		host_addr = addr;
		host_write_data = data;
		model[addr] = data;
		step();
		host_write_en = 1'b0;
	endtask

	task automatic host_read(input g729_pkg::mem_addr addr, output g729_pkg::word16 data);
		host_read_addr = addr;
		step();
		data = host_read_data;
	endtask

	task automatic verify_region(input g729_pkg::mem_addr base);
		g729_pkg::mem_addr addr;
		g729_pkg::word16 value;
		for (int i = 0; i < g729_pkg::lpc_order; i++) begin
			addr = base + g729_pkg::mem_addr'(i);
			host_read(addr, value);
			check_word($sformatf("address %0d", addr), model[addr], value);
		end
	endtask

	// One frame with an optional stray start while busy
	task automatic run_frame(input logic second_start);
		int cycle;
		logic seen;
		start = 1'b1;
		step();
		start = 1'b0;
		cycle = 0;
		seen = 1'b0;
		while (!seen && cycle < done_limit) begin
			@(negedge clock);
			cycle++;
			check_flag($sformatf("done in cycle %0d", cycle), cycle == done_cycle, done);
			check_flag($sformatf("busy in cycle %0d", cycle), cycle != done_cycle, busy);
			seen = done;
			step();
			start = second_start && (cycle == 4);
		end
		start = 1'b0;
		if (!seen) begin
			errors++;
			$display("%s: the frame never signalled done", test_name);
		end else begin
			// done is a single-cycle pulse
			@(negedge clock);
			check_flag("done after the pulse", 1'b0, done);
			check_flag("busy after the pulse", 1'b0, busy);
			step();
		end
		for (int i = 0; i < g729_pkg::lpc_order; i++) begin
			model[g729_pkg::lsp_int_base + i] = interpolate(model[g729_pkg::lsp_new_base + i],
					model[g729_pkg::lsp_old_base + i]);
			model[g729_pkg::lsp_old_base + i] = model[g729_pkg::lsp_new_base + i];
		end
	endtask

	task automatic finish_test(input int errors_before);
		tests++;
		$display("%s finished with %0d errors", test_name, errors - errors_before);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reset_and_host_access();
		int errors_before;
		g729_pkg::mem_addr addr;
		errors_before = errors;
		test_name = "reset_and_host_access";
		@(negedge clock);
		check_flag("busy after reset", 1'b0, busy);
		check_flag("done after reset", 1'b0, done);
		step();
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < g729_pkg::lpc_order; i++) begin
				addr = g729_pkg::mem_addr'(16 * r + i);
				host_write(addr, {addr, ~addr, addr[3:0]});
			end
		end
		verify_region(g729_pkg::lsp_old_base);
		verify_region(g729_pkg::lsp_new_base);
		verify_region(g729_pkg::lsp_int_base);
		finish_test(errors_before);
	endtask

	task automatic known_frame();
		int errors_before;
		errors_before = errors;
		test_name = "known_frame";
		for (int i = 0; i < g729_pkg::lpc_order; i++) begin
			host_write(g729_pkg::lsp_old_base + g729_pkg::mem_addr'(i), known_old[i]);
			host_write(g729_pkg::lsp_new_base + g729_pkg::mem_addr'(i), known_new[i]);
		end
		run_frame(1'b0);
		verify_region(g729_pkg::lsp_int_base);
		finish_test(errors_before);
	endtask

	task automatic region_copy();
		int errors_before;
		errors_before = errors;
		test_name = "region_copy";
		verify_region(g729_pkg::lsp_old_base);
		verify_region(g729_pkg::lsp_new_base);
		finish_test(errors_before);
	endtask

	task automatic back_to_back_frames();
		int errors_before;
		errors_before = errors;
		test_name = "back_to_back_frames";
		for (int f = 0; f < 5; f++) begin
			for (int i = 0; i < g729_pkg::lpc_order; i++) begin
				host_write(g729_pkg::lsp_new_base + g729_pkg::mem_addr'(i), random_word());
			end
			run_frame(1'b0);
			verify_region(g729_pkg::lsp_int_base);
			verify_region(g729_pkg::lsp_old_base);
		end
		finish_test(errors_before);
	endtask

	task automatic start_during_busy();
		int errors_before;
		errors_before = errors;
		test_name = "start_during_busy";
		for (int i = 0; i < g729_pkg::lpc_order; i++) begin
			host_write(g729_pkg::lsp_new_base + g729_pkg::mem_addr'(i), random_word());
		end
		run_frame(1'b1);
		// No second frame may follow
		repeat (30) begin
			@(negedge clock);
			check_flag("extra done", 1'b0, done);
			check_flag("extra busy", 1'b0, busy);
		end
		step();
		verify_region(g729_pkg::lsp_old_base);
		verify_region(g729_pkg::lsp_new_base);
		verify_region(g729_pkg::lsp_int_base);
		finish_test(errors_before);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		host_write_en = 1'b0;
		host_addr = '0;
		host_write_data = '0;
		host_read_addr = '0;
		lfsr_state = 16'd12;
		tests = 0;
		checks = 0;
		errors = 0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		reset_and_host_access();
		known_frame();
		region_copy();
		back_to_back_frames();
		start_during_busy();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* design/int_lpc_top.sv */
module int_lpc_top #(
	parameter int num_lanes = 2
) (
	input logic clock,
	input logic reset,
	input logic start,
	output logic busy,
	output logic done,
	input logic host_write_en,
	input g729_pkg::mem_addr host_addr,
	input g729_pkg::word16 host_write_data,
	input g729_pkg::mem_addr host_read_addr,
	output g729_pkg::word16 host_read_data
);

	g729_pkg::mem_addr read_addr_a;
	g729_pkg::mem_addr mem_read_addr_b;
	g729_pkg::word16 read_data_a;
	g729_pkg::word16 read_data_b;
	logic engine_write_en;
	g729_pkg::mem_addr engine_write_addr;
	g729_pkg::word16 engine_write_data;

	lane_if lane_bus [num_lanes] ();
	result_if result_bus [num_lanes] ();

	// Port b serves the host while idle
	assign host_read_data = read_data_b;

	scratch_mem i_scratch_mem (
		.clock(clock),
		.read_addr_a(read_addr_a),
		.read_addr_b(mem_read_addr_b),
		.read_data_a(read_data_a),
		.read_data_b(read_data_b),
		.engine_write_en(engine_write_en),
		.engine_write_addr(engine_write_addr),
		.engine_write_data(engine_write_data),
		.host_write_en(host_write_en),
		.host_write_addr(host_addr),
		.host_write_data(host_write_data)
	);

	int_lpc_ctrl #(.num_lanes(num_lanes)) i_int_lpc_ctrl (
		.clock(clock),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.read_addr_a(read_addr_a),
		.host_read_addr(host_read_addr),
		.read_data_a(read_data_a),
		.read_data_b(read_data_b),
		.mem_read_addr_b(mem_read_addr_b),
		.lanes(lane_bus)
	);

	for (genvar g = 0; g < num_lanes; g++) begin : g_lane
		interp_lane i_interp_lane (
			.clock(clock),
			.reset(reset),
			.item(lane_bus[g]),
			.result(result_bus[g])
		);
	end

	result_collector #(.num_lanes(num_lanes)) i_result_collector (
		.clock(clock),
		.reset(reset),
		.results(result_bus),
		.write_en(engine_write_en),
		.write_addr(engine_write_addr),
		.write_data(engine_write_data),
		.done(done)
	);

endmodule

/* design/result_collector.sv */
module result_collector #(
	parameter int num_lanes = 2
) (
	input logic clock,
	input logic reset,
	result_if.collector results [num_lanes],
	output logic write_en,
	output g729_pkg::mem_addr write_addr,
	output g729_pkg::word16 write_data,
	output logic done
);

	localparam logic [4:0] last_write = 5'(2 * g729_pkg::lpc_order - 1);

	logic [num_lanes-1:0] lane_valid;
	g729_pkg::lane_op lane_tag [num_lanes];
	logic [3:0] lane_index [num_lanes];
	g729_pkg::word16 lane_value [num_lanes];

	g729_pkg::lane_op sel_op;
	logic [3:0] sel_index;
	g729_pkg::word16 sel_value;
	logic [4:0] write_count;

	for (genvar g = 0; g < num_lanes; g++) begin : g_gather
		assign lane_valid[g] = results[g].valid;
		assign lane_tag[g] = results[g].op;
		assign lane_index[g] = results[g].index;
		assign lane_value[g] = results[g].value;
	end

	// At most one lane is valid in any cycle
	always_comb begin
		sel_op = g729_pkg::op_average;
		sel_index = '0;
		sel_value = '0;
		for (int k = 0; k < num_lanes; k++) begin
			if (lane_valid[k]) begin
				sel_op = lane_tag[k];
				sel_index = lane_index[k];
				sel_value = lane_value[k];
			end
		end
	end

	////////////////////////////////
	// Write back
	////////////////////////////////

	assign write_en = |lane_valid;
	assign write_data = sel_value;
	assign write_addr = ((sel_op == g729_pkg::op_copy) ? g729_pkg::lsp_old_base
			: g729_pkg::lsp_int_base) + g729_pkg::mem_addr'(sel_index);

	always_ff @(posedge clock) begin
		if (reset) begin
			write_count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (write_en) begin
				if (write_count == last_write) begin
					write_count <= '0;
					done <= 1'b1;
				end else begin
					write_count <= write_count + 5'd1;
				end
			end
		end
	end

endmodule

/* design/interp_lane.sv */
module interp_lane (
	input logic clock,
	input logic reset,
	lane_if.lane item,
	result_if.lane result
);

	logic s1_valid;
	g729_pkg::lane_op s1_op;
	logic [3:0] s1_index;
	g729_pkg::word16 s1_a;
	g729_pkg::word16 s1_b;

	////////////////////////////////
	// Stage one halves the operands
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= item.valid;
		end
	end

	always_ff @(posedge clock) begin
		s1_op <= item.op;
		s1_index <= item.index;
		if (item.op == g729_pkg::op_copy) begin
			s1_a <= item.a;
			s1_b <= '0;
		end else begin
			s1_a <= item.a >>> 1;
			s1_b <= item.b >>> 1;
		end
	end

	////////////////////////////////
	// Stage two sums the halves
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= s1_valid;
		end
	end

	// Sum of two halves cannot overflow
	always_ff @(posedge clock) begin
		result.op <= s1_op;
		result.index <= s1_index;
		result.value <= s1_a + s1_b;
	end

endmodule

/* design/int_lpc_ctrl.sv */
module int_lpc_ctrl #(
	parameter int num_lanes = 2
) (
	input logic clock,
	input logic reset,
	input logic start,
	output logic busy,
	input logic done,
	output g729_pkg::mem_addr read_addr_a,
	input g729_pkg::mem_addr host_read_addr,
	input g729_pkg::word16 read_data_a,
	input g729_pkg::word16 read_data_b,
	output g729_pkg::mem_addr mem_read_addr_b,
	lane_if.ctrl lanes [num_lanes]
);

	localparam logic [3:0] last_index = 4'(g729_pkg::lpc_order - 1);

	g729_pkg::ctrl_state state;
	logic [3:0] index;
	logic issue;
	g729_pkg::lane_op issue_op;
	g729_pkg::mem_addr read_addr_b;

	// Tags of the read in flight
	logic item_valid;
	g729_pkg::lane_op item_op;
	logic [3:0] item_index;
	logic [3:0] lane_sel;

	////////////////////////////////
	// State machine
	////////////////////////////////

	// Low already in the done cycle so a new start is taken there
	assign busy = (state != g729_pkg::st_idle) && !done;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= g729_pkg::st_idle;
			index <= '0;
		end else begin
			case (state)
				g729_pkg::st_idle: begin
					index <= '0;
					if (start) begin
						state <= g729_pkg::st_average;
					end
				end
				g729_pkg::st_average: begin
					if (index == last_index) begin
						state <= g729_pkg::st_copy;
						index <= '0;
					end else begin
						index <= index + 4'd1;
					end
				end
				g729_pkg::st_copy: begin
					if (index == last_index) begin
						state <= g729_pkg::st_wait;
						index <= '0;
					end else begin
						index <= index + 4'd1;
					end
				end
				g729_pkg::st_wait: begin
					// Back-to-back frame if start comes with done
					if (done) begin
						state <= start ? g729_pkg::st_average : g729_pkg::st_idle;
					end
				end
				default: state <= g729_pkg::st_idle;
			endcase
		end
	end

	////////////////////////////////
	// Read addresses
	////////////////////////////////

	assign issue = (state == g729_pkg::st_average) || (state == g729_pkg::st_copy);
	assign issue_op = (state == g729_pkg::st_copy) ? g729_pkg::op_copy : g729_pkg::op_average;

	assign read_addr_a = g729_pkg::lsp_new_base + g729_pkg::mem_addr'(index);
	assign read_addr_b = g729_pkg::lsp_old_base + g729_pkg::mem_addr'(index);
	assign mem_read_addr_b = busy ? read_addr_b : host_read_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			item_valid <= 1'b0;
		end else begin
			item_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		item_op <= issue_op;
		item_index <= index;
	end

	////////////////////////////////
	// Dispatch of item i to lane i mod num_lanes
	////////////////////////////////

	assign lane_sel = 4'(item_index % num_lanes);

	for (genvar g = 0; g < num_lanes; g++) begin : g_dispatch
		assign lanes[g].valid = item_valid && (lane_sel == 4'(g));
		assign lanes[g].op = item_op;
		assign lanes[g].index = item_index;
		assign lanes[g].a = read_data_a;
		assign lanes[g].b = read_data_b;
	end

endmodule

/* design/scratch_mem.sv */
module scratch_mem (
	input logic clock,
	input g729_pkg::mem_addr read_addr_a,
	input g729_pkg::mem_addr read_addr_b,
	output g729_pkg::word16 read_data_a,
	output g729_pkg::word16 read_data_b,
	input logic engine_write_en,
	input g729_pkg::mem_addr engine_write_addr,
	input g729_pkg::word16 engine_write_data,
	input logic host_write_en,
	input g729_pkg::mem_addr host_write_addr,
	input g729_pkg::word16 host_write_data
);

	localparam int depth = 2 ** $bits(g729_pkg::mem_addr);

	g729_pkg::word16 mem [depth];

	////////////////////////////////
	// Write ports
	////////////////////////////////

	// Engine has priority over host
	always_ff @(posedge clock) begin
		if (engine_write_en) begin
			mem[engine_write_addr] <= engine_write_data;
		end else if (host_write_en) begin
			mem[host_write_addr] <= host_write_data;
		end
	end

	////////////////////////////////
	// Registered reads
	////////////////////////////////

	always_ff @(posedge clock) begin
		read_data_a <= mem[read_addr_a];
		read_data_b <= mem[read_addr_b];
	end

endmodule

/* design/lane_if.sv */
////////////////////////////////
// Controller to lane
////////////////////////////////

interface lane_if;
	logic valid;
	g729_pkg::lane_op op;
	logic [3:0] index;
	// a carries lsp_new and b carries lsp_old
	g729_pkg::word16 a;
	g729_pkg::word16 b;

	modport ctrl (
		output valid, op, index, a, b
	);

	modport lane (
		input valid, op, index, a, b
	);
endinterface

////////////////////////////////
// Lane to collector
////////////////////////////////

interface result_if;
	logic valid;
	g729_pkg::lane_op op;
	logic [3:0] index;
	g729_pkg::word16 value;

	modport lane (
		output valid, op, index, value
	);

	modport collector (
		input valid, op, index, value
	);
endinterface

/* design/g729_pkg.sv */
package g729_pkg;

	////////////////////////////////
	// Data and sizes
	////////////////////////////////

	// Q15 coefficient word
	typedef logic signed [15:0] word16;

	localparam int lpc_order = 10;

	typedef logic [5:0] mem_addr;

	////////////////////////////////
	// Scratch memory map
	////////////////////////////////

	localparam mem_addr lsp_old_base = 6'd0;
	localparam mem_addr lsp_new_base = 6'd16;
	localparam mem_addr lsp_int_base = 6'd32;

	////////////////////////////////
	// Encodings
	////////////////////////////////

	typedef enum logic {
		op_average,
		op_copy
	} lane_op;

	typedef enum logic [1:0] {
		st_idle,
		st_average,
		st_copy,
		st_wait
	} ctrl_state;

endpackage
